// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= db_tb
FILELIST  ?= db.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== db.f ====
db_pkg.sv
db_ram_sdp.sv
db_store_array.sv
db_wb_decode.sv
db_execute.sv
db_result.sv
db_top.sv
db_assert.sv
db_tb.sv

// ==== db_assert.sv ====
`timescale 1ns/1ns

module db_assert (
    input logic clk,
    input logic rst,
    input logic init,
    input logic init_done,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);
    int unsigned fail_count = 0;

    logic       pending;
    logic       start;
    logic       ready_start;
    logic [9:0] sweep_cnt;

    // Bus cycle accepted by the slave, one at a time until ack
    assign start       = wb_cyc && wb_stb && !pending;
    assign ready_start = start && init_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (start) begin
            pending <= 1'b1;
        end else if (wb_ack) begin
            pending <= 1'b0;
        end
    end

    // Cycles since the last clearing sweep began
    always_ff @(posedge clk) begin
        if (rst || (init && init_done)) begin
            sweep_cnt <= '0;
        end else if (sweep_cnt != '1) begin
            sweep_cnt <= sweep_cnt + 10'd1;
        end
    end

    // ------------------------------
    // Protocol and timing
    // ------------------------------
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack stayed high for more than one cycle");
            fail_count++;
        end

    ack_latency: assert property (@(posedge clk) disable iff (rst)
        $past(ready_start, 4) |-> wb_ack)
        else begin
            $error("wb_ack missing three cycles after the accepted strobe");
            fail_count++;
        end

    ack_not_early: assert property (@(posedge clk) disable iff (rst)
        ($past(ready_start, 1) || $past(ready_start, 2) || $past(ready_start, 3)) |-> !wb_ack)
        else begin
            $error("wb_ack arrived before three cycles had passed");
            fail_count++;
        end

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack raised outside a bus cycle");
            fail_count++;
        end

    sweep_low: assert property (@(posedge clk) disable iff (rst)
        init_done |-> (sweep_cnt >= 10'd256))
        else begin
            $error("init_done rose before the 256 cycle sweep finished");
            fail_count++;
        end

endmodule : db_assert

bind db_top db_assert i_db_assert (
    .clk       ( clk ),
    .rst       ( rst ),
    .init      ( init ),
    .init_done ( init_done ),
    .wb_cyc    ( wb_cyc ),
    .wb_stb    ( wb_stb ),
    .wb_ack    ( wb_ack )
);

// ==== db_execute.sv ====
`timescale 1ns/1ns

module db_execute (
    input  logic                clk,
    input  logic                rst,

    // Operation from decode
    input  db_pkg::db_op_t      op,
    input  logic                op_valid,
    output logic                op_take,

    input  logic                rdy,

    // Store write side
    output logic                wr_req,
    output db_pkg::db_key_t     wr_key,
    output db_pkg::db_value_t   wr_value,
    output logic                wr_valid,
    input  logic                wr_ack,

    // Store read side
    output logic                rd_req,
    output db_pkg::db_key_t     rd_key,
    input  logic                rd_ack,
    input  db_pkg::db_entry_t   rd_entry,

    // Completed operation
    output db_pkg::db_result_t  res,
    output logic                res_valid
);
    logic               busy;
    logic               is_write;
    db_pkg::db_opcode_t code_q;
    db_pkg::db_key_t    key_q;

    assign is_write = (op.code == db_pkg::OP_INSERT) || (op.code == db_pkg::OP_DELETE);

    // Take a new op only with the store ready and nothing outstanding
    assign op_take  = op_valid && rdy && !busy;

    // ------------------------------
    // Issue control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            wr_req <= 1'b0;
            rd_req <= 1'b0;
        end else begin
            if (op_take) begin
                busy   <= 1'b1;
                wr_req <= is_write;
                rd_req <= !is_write;
            end else begin
                // Request drops once the store samples it while ready
                if (wr_req && rdy) begin
                    wr_req <= 1'b0;
                end
                if (rd_req && rdy) begin
                    rd_req <= 1'b0;
                end
                if (wr_ack || rd_ack) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (op_take) begin
            code_q <= op.code;
            key_q  <= op.key;
            if (op.code == db_pkg::OP_INSERT) begin
                wr_value <= op.value;
                wr_valid <= 1'b1;
            end else begin
                // Delete leaves a cleared record behind
                wr_value <= '0;
                wr_valid <= 1'b0;
            end
        end
    end

    assign wr_key = key_q;
    assign rd_key = key_q;

    // ------------------------------
    // Result
    // ------------------------------
    assign res_valid = wr_ack || rd_ack;

    always_comb begin
        res.code  = code_q;
        res.entry = rd_ack ? rd_entry : '0;
    end

endmodule : db_execute

// ==== db_pkg.sv ====
package db_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int DB_KEY_WID    = 8;
    localparam int DB_VALUE_WID  = 32;
    localparam int WB_ADR_WID    = 16;

    // Address map of the Wishbone port
    localparam int WB_KEY_LSB    = 2;
    localparam int WB_REGION_BIT = 10;

    // ------------------------------
    // Basic types
    // ------------------------------
    typedef logic [DB_KEY_WID-1:0]   db_key_t;
    typedef logic [DB_VALUE_WID-1:0] db_value_t;

    typedef enum logic [1:0] {
        OP_LOOKUP = 2'd0,
        OP_INSERT = 2'd1,
        OP_DELETE = 2'd2,
        OP_QUERY  = 2'd3
    } db_opcode_t;

    // ------------------------------
    // Grouped signals
    // ------------------------------
    // Operation from decode to execute
    typedef struct packed {
        db_opcode_t code;
        db_key_t    key;
        db_value_t  value;
    } db_op_t;

    // Record as read back from the store
    typedef struct packed {
        logic      valid;
        db_value_t value;
    } db_entry_t;

    // Completed operation from execute to result
    typedef struct packed {
        db_opcode_t code;
        db_entry_t  entry;
    } db_result_t;

endpackage : db_pkg

// ==== db_ram_sdp.sv ====
`timescale 1ns/1ns

module db_ram_sdp #(
    parameter int  ADDR_WID = 8,
    parameter type DATA_T   = logic [31:0]
)(
    input  logic                clk,
    input  logic                rst,

    // Restart the clearing sweep
    input  logic                clear,

    // Write side
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  DATA_T               wr_data,

    // Read side, one cycle latency
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output DATA_T               rd_data,

    output logic                init_done
);
    localparam int DEPTH = 2 ** ADDR_WID;

    typedef enum logic {
        ST_CLEAR,
        ST_READY
    } state_t;

    state_t              state;
    logic [ADDR_WID-1:0] clr_addr;

    DATA_T mem [DEPTH];

    // ------------------------------
    // Clear FSM
    // ------------------------------
    // One address per cycle, full sweep before ready
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_CLEAR;
            clr_addr <= '0;
        end else begin
            case (state)
                ST_CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == ADDR_WID'(DEPTH - 1)) begin
                        state <= ST_READY;
                    end
                end
                default: begin
                    if (clear) begin
                        state    <= ST_CLEAR;
                        clr_addr <= '0;
                    end
                end
            endcase
        end
    end

    assign init_done = (state == ST_READY);

    // ------------------------------
    // Memory array
    // ------------------------------
    // User writes are held off while the sweep runs
    always_ff @(posedge clk) begin
        if (state == ST_CLEAR) begin
            mem[clr_addr] <= '0;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : db_ram_sdp

// ==== db_result.sv ====
`timescale 1ns/1ns

module db_result (
    input  logic                clk,
    input  logic                rst,

    input  db_pkg::db_result_t  res,
    input  logic                res_valid,

    // Wishbone response
    output db_pkg::db_value_t   wb_dat_r,
    output logic                wb_ack
);
    db_pkg::db_value_t rd_data;

    // ------------------------------
    // Read data by opcode
    // ------------------------------
    always_comb begin
        case (res.code)
            db_pkg::OP_LOOKUP: begin
                rd_data = res.entry.valid ? res.entry.value : '0;
            end
            db_pkg::OP_QUERY: begin
                // Presence flag in bit 0
                rd_data = db_pkg::db_value_t'(res.entry.valid);
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule : db_result

// ==== db_store_array.sv ====
`timescale 1ns/1ns

module db_store_array #(
    parameter type KEY_T       = logic [7:0],
    parameter type VALUE_T     = logic [31:0],
    parameter bit  TRACK_VALID = 1
)(
    input  logic   clk,
    input  logic   rst,

    input  logic   init,
    output logic   init_done,
    output logic   rdy,

    // Write side
    input  logic   wr_req,
    input  KEY_T   wr_key,
    input  VALUE_T wr_value,
    input  logic   wr_valid,
    output logic   wr_ack,

    // Read side
    input  logic   rd_req,
    input  KEY_T   rd_key,
    output logic   rd_ack,
    output VALUE_T rd_value,
    output logic   rd_valid
);
    localparam int KEY_WID   = $bits(KEY_T);
    localparam int VALUE_WID = $bits(VALUE_T);
    // Valid bit sits above the value when it is kept
    localparam int ENTRY_WID = TRACK_VALID ? VALUE_WID + 1 : VALUE_WID;

    typedef logic [ENTRY_WID-1:0] entry_t;

    logic   ram_wr_en;
    logic   ram_rd_en;
    entry_t ram_wr_data;
    entry_t ram_rd_data;

    // ------------------------------
    // Request gating and acks
    // ------------------------------
    assign rdy       = init_done;
    assign ram_wr_en = wr_req && rdy;
    assign ram_rd_en = rd_req && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= ram_wr_en;
            rd_ack <= ram_rd_en;
        end
    end

    db_ram_sdp #(
        .ADDR_WID ( KEY_WID ),
        .DATA_T   ( entry_t )
    ) i_db_ram_sdp (
        .clk       ( clk ),
        .rst       ( rst ),
        .clear     ( init ),
        .wr_en     ( ram_wr_en ),
        .wr_addr   ( wr_key ),
        .wr_data   ( ram_wr_data ),
        .rd_en     ( ram_rd_en ),
        .rd_addr   ( rd_key ),
        .rd_data   ( ram_rd_data ),
        .init_done ( init_done )
    );

    // ------------------------------
    // Entry layout
    // ------------------------------
    generate
        if (TRACK_VALID) begin : g_valid_tracked
            assign ram_wr_data           = {wr_valid, wr_value};
            assign {rd_valid, rd_value}  = ram_rd_data;
        end else begin : g_valid_untracked
            // Every stored record counts as present
            assign ram_wr_data = wr_value;
            assign rd_value    = ram_rd_data;
            assign rd_valid    = 1'b1;
        end
    endgenerate

endmodule : db_store_array

// ==== db_tb.sv ====
`timescale 1ns/1ns

module db_tb;

    localparam int          CLK_PERIOD  = 40;
    localparam int          DRIVE_DLY   = 2;
    localparam int          RST_CYCLES  = 16;
    localparam int          NUM_KEYS    = 256;
    localparam int          FILL_KEYS   = 8;
    localparam int          MIX_OPS     = 200;
    localparam logic [31:0] SEED        = 32'h69e548e0;
    // Bus cycles issued by all tests together
    localparam int          NUM_TXNS    = 1 + 2 * FILL_KEYS + 7 + 2 * FILL_KEYS + NUM_KEYS + MIX_OPS;
    localparam int          TXN_CYCLES  = 6;
    localparam int          SWEEP_SLACK = 300;
    // Address bits outside key and region
    localparam logic [15:0] IGNORED_BITS = 16'hf803;

    logic        clk;
    logic        rst;
    logic        init;
    logic        init_done;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // Reference model of the record table
    logic        model_valid [NUM_KEYS];
    logic [31:0] model_value [NUM_KEYS];
    logic [7:0]  fill_keys [FILL_KEYS];
    logic [15:0] adr_noise;

    int check_errors;
    int tests_passed;
    int tests_failed;
    int fails_at_start;

    db_top #(
        .TRACK_VALID ( 1'b1 )
    ) uut (
        .clk       ( clk ),
        .rst       ( rst ),
        .init      ( init ),
        .init_done ( init_done ),
        .wb_cyc    ( wb_cyc ),
        .wb_stb    ( wb_stb ),
        .wb_we     ( wb_we ),
        .wb_adr    ( wb_adr ),
        .wb_dat_w  ( wb_dat_w ),
        .wb_dat_r  ( wb_dat_r ),
        .wb_ack    ( wb_ack )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic int failures();
        return check_errors + int'(uut.i_db_assert.fail_count);
    endfunction

    // Key in bits 9:2, region in bit 10
    function automatic logic [15:0] bus_addr(input logic [7:0] key, input logic ctrl);
        return {5'd0, ctrl, key, 2'b00} | (adr_noise & IGNORED_BITS);
    endfunction

    task automatic run_cycle(input logic we, input logic [15:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        while (!wb_ack) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        rdata = wb_dat_r;
        // Ack is taken on the next edge, bus released after it
        @(posedge clk);
        #DRIVE_DLY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic expect_data(input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: wb_dat_r expected %h, got %h", $time, exp, got);
            check_errors++;
        end
    endtask

    task automatic insert_key(input logic [7:0] key, input logic [31:0] value);
        logic [31:0] rdata;
        run_cycle(1'b1, bus_addr(key, 1'b0), value, rdata);
        expect_data(rdata, 32'd0);
        model_valid[key] = 1'b1;
        model_value[key] = value;
    endtask

    task automatic delete_key(input logic [7:0] key);
        logic [31:0] rdata;
        run_cycle(1'b1, bus_addr(key, 1'b1), $urandom, rdata);
        expect_data(rdata, 32'd0);
        model_valid[key] = 1'b0;
        model_value[key] = '0;
    endtask

    task automatic lookup_key(input logic [7:0] key);
        logic [31:0] rdata;
        run_cycle(1'b0, bus_addr(key, 1'b0), '0, rdata);
        expect_data(rdata, model_valid[key] ? model_value[key] : 32'd0);
    endtask

    task automatic query_key(input logic [7:0] key);
        logic [31:0] rdata;
        run_cycle(1'b0, bus_addr(key, 1'b1), '0, rdata);
        expect_data(rdata, {31'd0, model_valid[key]});
    endtask

    task automatic clear_model();
        for (int k = 0; k < NUM_KEYS; k++) begin
            model_valid[k] = 1'b0;
            model_value[k] = '0;
        end
    endtask

    task automatic finish_test(input string name);
        if (failures() == fails_at_start) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
        fails_at_start = failures();
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    initial begin
        logic [31:0] rdata;
        logic [7:0]  key;
        clk            = 1'b0;
        rst            = 1'b1;
        init           = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        adr_noise      = '0;
        check_errors   = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        fails_at_start = 0;
        void'($urandom(SEED));
        clear_model();
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // Read issued while the RAM is still clearing
        run_cycle(1'b0, bus_addr(8'h5a, 1'b0), '0, rdata);
        assert (init_done) else begin
            $display("Read during init was acknowledged before init_done rose at %0t ns", $time);
            check_errors++;
        end
        expect_data(rdata, 32'd0);
        finish_test("init");

        for (int i = 0; i < FILL_KEYS; i++) begin
            fill_keys[i] = 8'($urandom_range(0, 127));
            insert_key(fill_keys[i], $urandom);
        end
        for (int i = 0; i < FILL_KEYS; i++) begin
            lookup_key(fill_keys[i]);
        end
        finish_test("insert then lookup");

        delete_key(fill_keys[0]);
        query_key(fill_keys[0]);
        lookup_key(fill_keys[0]);
        for (int i = 1; i < 5; i++) begin
            lookup_key(fill_keys[i]);
        end
        finish_test("delete");

        // Upper half of the key space is never written
        for (int i = 0; i < FILL_KEYS; i++) begin
            query_key(fill_keys[i]);
            query_key(8'(128 + i * 16));
        end
        finish_test("query");

        @(posedge clk);
        #DRIVE_DLY;
        init = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        init = 1'b0;
        clear_model();
        while (!init_done) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        for (int k = 0; k < NUM_KEYS; k++) begin
            query_key(8'(k));
        end
        finish_test("re-init");

        for (int n = 0; n < MIX_OPS; n++) begin
            key = 8'($urandom_range(0, 255));
            // Half the keys land in a small set so records get reused
            if ($urandom_range(0, 1) == 0) begin
                key[7:4] = 4'h0;
            end
            adr_noise = 16'($urandom);
            case ($urandom_range(0, 3))
                0:       insert_key(key, $urandom);
                1:       delete_key(key);
                2:       lookup_key(key);
                default: query_key(key);
            endcase
        end
        adr_noise = '0;
        finish_test("random mix");

        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, check_errors, uut.i_db_assert.fail_count);
        if (tests_failed == 0 && failures() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_TXNS * TXN_CYCLES + 3 * SWEEP_SLACK) * CLK_PERIOD);
        $display("Run timed out before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule : db_tb

// ==== db_top.sv ====
`timescale 1ns/1ns

module db_top #(
    parameter bit TRACK_VALID = 1
)(
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            init,
    output logic                            init_done,

    // Wishbone classic slave
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [db_pkg::WB_ADR_WID-1:0]   wb_adr,
    input  db_pkg::db_value_t               wb_dat_w,
    output db_pkg::db_value_t               wb_dat_r,
    output logic                            wb_ack
);
    // ------------------------------
    // Internal wiring
    // ------------------------------
    db_pkg::db_op_t          op;
    logic                    op_valid;
    logic                    op_take;
    logic                    rdy;

    logic                    wr_req;
    db_pkg::db_key_t         wr_key;
    db_pkg::db_value_t       wr_value;
    logic                    wr_valid;
    logic                    wr_ack;

    logic                    rd_req;
    db_pkg::db_key_t         rd_key;
    logic                    rd_ack;
    wire db_pkg::db_entry_t  rd_entry;

    db_pkg::db_result_t      res;
    logic                    res_valid;

    db_wb_decode i_db_wb_decode (
        .clk      ( clk ),
        .rst      ( rst ),
        .wb_cyc   ( wb_cyc ),
        .wb_stb   ( wb_stb ),
        .wb_we    ( wb_we ),
        .wb_adr   ( wb_adr ),
        .wb_dat_w ( wb_dat_w ),
        .wb_ack   ( wb_ack ),
        .op       ( op ),
        .op_valid ( op_valid ),
        .op_take  ( op_take )
    );

    db_execute i_db_execute (
        .clk       ( clk ),
        .rst       ( rst ),
        .op        ( op ),
        .op_valid  ( op_valid ),
        .op_take   ( op_take ),
        .rdy       ( rdy ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_value  ( wr_value ),
        .wr_valid  ( wr_valid ),
        .wr_ack    ( wr_ack ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_ack    ( rd_ack ),
        .rd_entry  ( rd_entry ),
        .res       ( res ),
        .res_valid ( res_valid )
    );

    db_result i_db_result (
        .clk       ( clk ),
        .rst       ( rst ),
        .res       ( res ),
        .res_valid ( res_valid ),
        .wb_dat_r  ( wb_dat_r ),
        .wb_ack    ( wb_ack )
    );

    db_store_array #(
        .KEY_T       ( db_pkg::db_key_t ),
        .VALUE_T     ( db_pkg::db_value_t ),
        .TRACK_VALID ( TRACK_VALID )
    ) i_db_store_array (
        .clk       ( clk ),
        .rst       ( rst ),
        .init      ( init ),
        .init_done ( init_done ),
        .rdy       ( rdy ),
        .wr_req    ( wr_req ),
        .wr_key    ( wr_key ),
        .wr_value  ( wr_value ),
        .wr_valid  ( wr_valid ),
        .wr_ack    ( wr_ack ),
        .rd_req    ( rd_req ),
        .rd_key    ( rd_key ),
        .rd_ack    ( rd_ack ),
        .rd_value  ( rd_entry.value ),
        .rd_valid  ( rd_entry.valid )
    );

endmodule : db_top

// ==== db_wb_decode.sv ====
`timescale 1ns/1ns

module db_wb_decode (
    input  logic                            clk,
    input  logic                            rst,

    // Wishbone classic slave inputs
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    input  logic [db_pkg::WB_ADR_WID-1:0]   wb_adr,
    input  db_pkg::db_value_t               wb_dat_w,
    input  logic                            wb_ack,

    // Operation towards execute
    output db_pkg::db_op_t                  op,
    output logic                            op_valid,
    input  logic                            op_take
);
    logic              busy;
    logic              capture;
    logic              ctrl_region;
    db_pkg::db_opcode_t code;

    // Only one bus cycle in flight until it is acknowledged
    assign capture     = wb_cyc && wb_stb && !busy;
    assign ctrl_region = wb_adr[db_pkg::WB_REGION_BIT];

    // ------------------------------
    // Opcode mapping
    // ------------------------------
    always_comb begin
        case ({wb_we, ctrl_region})
            2'b10:   code = db_pkg::OP_INSERT;
            2'b11:   code = db_pkg::OP_DELETE;
            2'b01:   code = db_pkg::OP_QUERY;
            default: code = db_pkg::OP_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            if (capture) begin
                busy     <= 1'b1;
                op_valid <= 1'b1;
            end else begin
                if (op_take) begin
                    op_valid <= 1'b0;
                end
                if (wb_ack) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Operation payload
    always_ff @(posedge clk) begin
        if (capture) begin
            op.code  <= code;
            op.key   <= wb_adr[db_pkg::WB_KEY_LSB +: db_pkg::DB_KEY_WID];
            op.value <= wb_dat_w;
        end
    end

endmodule : db_wb_decode
